/* fetch_top.f */
hw/axi_pkg.sv
hw/fetch_pkg.sv
hw/fetch_pc.sv
hw/fetch_axi_master.sv
hw/inst_rom_axi.sv
hw/fetch_top.sv
tb/tb_fetch_top.sv

/* hw/axi_pkg.sv */
package axi_pkg;

    // AXI-lite read channel widths
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_RESP_W = 2;

    // byte address on AR
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

    // read data on R
    typedef logic [AXI_DATA_W-1:0] axi_data_t;

    // response code on R
    typedef logic [AXI_RESP_W-1:0] axi_resp_t;

    // normal access, the only code the ROM returns
    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

endpackage

/* hw/fetch_axi_master.sv */
`timescale 1ns/1ps

module fetch_axi_master (
    input  logic               clk,
    input  logic               rst,
    input  logic               retire,
    input  fetch_pkg::pc_t     pc,
    output axi_pkg::axi_addr_t araddr,
    output logic               arvalid,
    input  logic               arready,
    output logic               rready,
    input  logic               rvalid,
    input  axi_pkg::axi_data_t rdata,
    output logic               inst_valid,
    output fetch_pkg::inst_t   inst
);
    import fetch_pkg::*;

    fetch_state_t state;
    // one counter serves both delays, states never overlap
    delay_cnt_t   delay_cnt;
    logic         ar_fire;
    logic         r_fire;

    // channel handshakes
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            // first fetch goes out straight after reset
            state     <= addr;
            delay_cnt <= '0;
        end else begin
            case (state)
                issue_wait: begin
                    // zero count means idle, waiting for retire
                    if (retire) begin
                        delay_cnt <= delay_cnt_t'(AR_ISSUE_DELAY - 1);
                    end else if (delay_cnt == delay_cnt_t'(1)) begin
                        // last count, arvalid shows next cycle
                        delay_cnt <= '0;
                        state     <= addr;
                    end else if (delay_cnt != '0) begin
                        delay_cnt <= delay_cnt - delay_cnt_t'(1);
                    end
                end
                addr: begin
                    // arvalid held here until the slave takes it
                    if (ar_fire) begin
                        delay_cnt <= delay_cnt_t'(R_ACCEPT_DELAY - 1);
                        state     <= data;
                    end
                end
                data: begin
                    // accept delay runs out, then rready waits for rvalid
                    if (r_fire) begin
                        state <= issue_wait;
                    end else if (delay_cnt != '0) begin
                        delay_cnt <= delay_cnt - delay_cnt_t'(1);
                    end
                end
                default: begin
                    state     <= issue_wait;
                    delay_cnt <= '0;
                end
            endcase
        end
    end

    // AR side
    assign arvalid = (state == addr);
    // pc is frozen while a fetch is in flight
    assign araddr  = pc;

    // R side, ready once the accept delay is spent
    assign rready = (state == data) && (delay_cnt == '0);

    // one-cycle delivery on the R handshake
    assign inst_valid = r_fire;
    assign inst       = rdata;

endmodule

/* hw/fetch_pc.sv */
`timescale 1ns/1ps

module fetch_pc (
    input  logic           clk,
    input  logic           rst,
    input  logic           retire,
    input  logic           redirect,
    input  fetch_pkg::pc_t redirect_pc,
    output fetch_pkg::pc_t pc
);
    import fetch_pkg::*;

    // value taken at the next retire
    pc_t pc_next;

    // redirect wins over the sequential step
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else begin
            pc_next = pc + PC_STEP;
        end
    end

    // pc only moves on retire
    // otherwise it holds for the fetch in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (retire) begin
            pc <= pc_next;
        end
    end

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

    // program counter and instruction word
    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;

    // first fetch address out of reset
    localparam pc_t RESET_PC = 32'h8000_0000;
    // sequential step, one 32-bit word
    localparam pc_t PC_STEP = 32'd4;

    // slow-master delays, in cycles
    localparam int AR_ISSUE_DELAY = 6;
    localparam int R_ACCEPT_DELAY = 4;
    // ROM response latency after AR handshake
    localparam int ROM_LATENCY = 2;

    // shared width for the delay and latency counters
    localparam int DELAY_W = 3;
    typedef logic [DELAY_W-1:0] delay_cnt_t;

    // ROM geometry, word indexed
    localparam int ROM_WORDS = 32;
    localparam int ROM_INDEX_W = 5;
    typedef logic [ROM_INDEX_W-1:0] rom_index_t;

    // fetch control states
    typedef enum logic [1:0] {issue_wait, addr, data} fetch_state_t;

endpackage

/* hw/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             retire,
    input  logic             redirect,
    input  fetch_pkg::pc_t   redirect_pc,
    output logic             inst_valid,
    output fetch_pkg::pc_t   pc,
    output fetch_pkg::inst_t inst
);
    import axi_pkg::*;

    // AR channel
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    // R channel
    logic      rready;
    logic      rvalid;
    axi_data_t rdata;
    // always OKAY, not used by the fetch stage
    axi_resp_t rresp;

    // program counter, moved by the back end on retire
    fetch_pc pc_i (
        .clk         (clk),
        .rst         (rst),
        .retire      (retire),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

    // slow bus master, one fetch in flight
    fetch_axi_master master_i (
        .clk        (clk),
        .rst        (rst),
        .retire     (retire),
        .pc         (pc),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rready     (rready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .inst_valid (inst_valid),
        .inst       (inst)
    );

    // program store behind the read port
    inst_rom_axi rom_i (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rready  (rready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp)
    );

endmodule

/* hw/inst_rom_axi.sv */
`timescale 1ns/1ps

module inst_rom_axi (
    input  logic               clk,
    input  logic               rst,
    input  axi_pkg::axi_addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    input  logic               rready,
    output logic               rvalid,
    output axi_pkg::axi_data_t rdata,
    output axi_pkg::axi_resp_t rresp
);
    import axi_pkg::*;
    import fetch_pkg::*;

    // program image
    axi_data_t  rom [0:ROM_WORDS-1];
    rom_index_t rom_index;
    // one read in service
    logic       busy;
    delay_cnt_t lat_cnt;
    logic       ar_fire;
    logic       r_fire;

    initial begin
        $readmemh("prog.hex", rom);
    end

    // word index above the byte offset, wraps at ROM_WORDS
    assign rom_index = araddr[ROM_INDEX_W+1:2];

    // no new address accepted while a read is open
    assign arready = !busy;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
        end else if (ar_fire) begin
            busy    <= 1'b1;
            lat_cnt <= delay_cnt_t'(ROM_LATENCY - 1);
        end else if (r_fire) begin
            // read closed, free for the next address
            busy <= 1'b0;
        end else if (busy && (lat_cnt != '0)) begin
            lat_cnt <= lat_cnt - delay_cnt_t'(1);
        end
    end

    // word captured at the AR handshake
    // stays put while rvalid is high
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= rom[rom_index];
        end
    end

    // latency spent, hold until the master takes it
    assign rvalid = busy && (lat_cnt == '0);
    // ROM never faults
    assign rresp  = AXI_RESP_OKAY;

endmodule

/* prog.hex */
// one RV32 instruction word per line, in hex
// line order is ROM index, index 0 sits at the reset vector
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813
002081b3
40208233
0020f2b3
0020e333
0020c3b3
00209433
0020d4b3
0020a533
00112023
00012583
00208463
00209463
008000ef
000080e7
12345037
00000013

/* run.sh */
#!/bin/sh
# build and run from the project root so prog.hex is found
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f fetch_top.f --top-module tb_fetch_top \
    -o tb_fetch_top || exit 1
./obj_dir/tb_fetch_top > sim.log 2>&1
cat sim.log
grep -qx "STATUS: PASS" sim.log && exit 0 || exit 1

/* tb/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int NUM_RETIRES  = 200;
    localparam int RESET_CYCLES = 10;
    // 0 to MAX_GAP idle cycles between inst_valid and the next retire
    localparam int MAX_GAP      = 5;
    localparam int MARGIN       = 10;
    localparam int FETCH_CYCLES = AR_ISSUE_DELAY + R_ACCEPT_DELAY;
    // per-fetch limit well past the expected latency
    localparam int WAIT_LIMIT   = FETCH_CYCLES + MARGIN;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + (NUM_RETIRES + 1) * (FETCH_CYCLES + MAX_GAP + MARGIN);
    localparam logic [31:0] SEED = 32'hc7f874a8;
    // first byte address past the program image
    localparam pc_t WINDOW_END = RESET_PC + pc_t'(ROM_WORDS * 4);

    logic  clk;
    logic  rst;
    logic  retire;
    logic  redirect;
    pc_t   redirect_pc;
    logic  inst_valid;
    pc_t   pc;
    inst_t inst;

    // reference copy of the program
    inst_t       prog_model [0:ROM_WORDS-1];
    logic [31:0] lcg_state;
    // pc the model expects on the next delivery
    pc_t         exp_pc;
    int          wrap_checks;
    int          redirect_checks;

    fetch_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .retire      (retire),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_valid  (inst_valid),
        .pc          (pc),
        .inst        (inst)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        $readmemh("prog.hex", prog_model);
    end

    // numerical recipes constants
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // word index wraps every ROM_WORDS words
    function automatic inst_t model_inst(input pc_t addr_pc);
        rom_index_t idx;
        idx = rom_index_t'((addr_pc >> 2) % ROM_WORDS);
        return prog_model[idx];
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic fail_now(input string what);
        $display("error: %s", what);
        abort_run();
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // no delivery and a steady pc in a cycle without a fetch result
    task automatic check_idle_cycle();
        @(negedge clk);
        assert (!inst_valid) else
            fail_now("inst_valid pulsed again without a retire");
        check_word("pc", pc, exp_pc);
    endtask

    // counts falling edges until inst_valid shows up
    // pc must not move while the fetch is in flight
    task automatic wait_inst(output int cycles);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            n++;
            if (inst_valid) begin
                seen = 1'b1;
            end else begin
                check_word("pc", pc, exp_pc);
                assert (n < WAIT_LIMIT) else
                    fail_now("no inst_valid within the fetch wait limit");
            end
        end
        cycles = n;
    endtask

    initial begin
        int          i;
        int          cycles;
        int unsigned gap;
        logic [31:0] r;
        logic        do_redirect;
        pc_t         target;
        rst         <= 1'b1;
        retire      <= 1'b0;
        redirect    <= 1'b0;
        redirect_pc <= '0;
        lcg_state       = SEED;
        exp_pc          = RESET_PC;
        wrap_checks     = 0;
        redirect_checks = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // first fetch goes out without a retire
        wait_inst(cycles);
        check_word("pc", pc, RESET_PC);
        check_word("inst", inst, prog_model[0]);

        for (i = 0; i < NUM_RETIRES; i++) begin
            r           = next_rand();
            // about one retire in eight redirects
            do_redirect = (r[31:29] == 3'b000);
            // word-aligned target inside the ROM window
            target      = RESET_PC + {25'd0, r[20:16], 2'b00};
            gap         = (r >> 8) % (MAX_GAP + 1);

            // step off the delivery edge
            @(posedge clk);
            repeat (gap) begin
                check_idle_cycle();
                @(posedge clk);
            end

            // target driven on every retire and ignored without redirect
            retire      <= 1'b1;
            redirect    <= do_redirect;
            redirect_pc <= target;
            check_idle_cycle();
            @(posedge clk);
            retire   <= 1'b0;
            redirect <= 1'b0;

            // retire rule
            if (do_redirect) begin
                exp_pc = target;
                redirect_checks++;
            end else begin
                exp_pc = exp_pc + 32'd4;
            end

            wait_inst(cycles);
            check_word("retire_to_inst_valid", cycles, FETCH_CYCLES);
            check_word("pc", pc, exp_pc);
            check_word("inst", inst, model_inst(exp_pc));
            // ROM index has wrapped past the image
            if (exp_pc >= WINDOW_END) begin
                wrap_checks++;
            end
        end

        assert (redirect_checks > 0) else
            fail_now("the stimulus never redirected the pc");
        assert (wrap_checks > 0) else
            fail_now("no fetch crossed the end of the ROM window");
        $display("STATUS: PASS");
        $finish;
    end

    // hard stop for a stuck handshake
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule
